// File: common/scope_pkg.sv
`default_nettype none

package scope_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	// raw ADC sample
	localparam int sample_width = 12;
	// top bits of a sample kept per frame and plotted
	localparam int trace_width = 8;
	// 1024 columns of history
	localparam int buf_addr_width = 10;
	localparam int coord_width = 10;
	localparam int num_channels = 4;

	//////////////////////////////////////////////////
	// screen geometry
	//////////////////////////////////////////////////

	// one buffer column per screen column, newest at the right edge
	localparam int screen_width = 800;
	// first plotted row, also the row offset of a0
	localparam int plot_top = 224;
	// a1 at 256, b0 at 288, b1 at 320
	localparam int channel_pitch = 32;
	// vertical grid line every 64 columns, horizontal every 32 rows
	localparam int grid_x_bits = 6;
	localparam int grid_y_bits = 5;

	//////////////////////////////////////////////////
	// colors as {red, green, blue}
	//////////////////////////////////////////////////

	localparam logic [23:0] color_a0 = 24'hFFFFFF;
	localparam logic [23:0] color_a1 = 24'hFF0000;
	localparam logic [23:0] color_b0 = 24'h00FF00;
	localparam logic [23:0] color_b1 = 24'h0000FF;
	localparam logic [23:0] color_grid = 24'h808080;
	localparam logic [23:0] color_black = 24'h000000;

	// types
	typedef logic [sample_width-1:0] sample_t;
	typedef logic [trace_width-1:0] trace_t;
	typedef logic [buf_addr_width-1:0] buf_addr_t;
	typedef logic [coord_width-1:0] coord_t;
	typedef logic [7:0] color_t;

	// a0, a1, b0, b1 from the top down, each as {max, min}
	typedef logic [2*num_channels*trace_width-1:0] trace_word_t;

endpackage

`default_nettype wire

// File: hdl/scope_frame_ctrl.sv
`default_nettype none

module scope_frame_ctrl (
	input  logic               clk,
	input  logic               reset,
	input  logic               blank,
	input  logic               vsync,
	output logic               frame_start,
	output logic               wr_en,
	output scope_pkg::buf_addr_t wr_addr,
	output scope_pkg::buf_addr_t rd_addr,
	output scope_pkg::coord_t  view_x,
	output scope_pkg::coord_t  view_y
);

	import scope_pkg::*;

	logic vsync_d1;
	logic blank_d1;
	logic vsync_rise;
	logic vsync_fall;
	logic blank_rise;
	coord_t xcnt;
	coord_t ycnt;
	coord_t view_x_d1;
	coord_t view_y_d1;

	assign vsync_rise = vsync && !vsync_d1;
	assign vsync_fall = !vsync && vsync_d1;
	assign blank_rise = blank && !blank_d1;

	//////////////////////////////////////////////////
	// frame strobes and write pointer
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d1 <= 1'b0;
			frame_start <= 1'b0;
			wr_en <= 1'b0;
			// first frame lands in column 800
			wr_addr <= buf_addr_t'(screen_width - 1);
		end else begin
			vsync_d1 <= vsync;
			// min/max hand-over at the start of vsync
			frame_start <= vsync_rise;
			// buffer write at the end of vsync when the held pairs are stable
			wr_en <= vsync_fall;
			if (vsync_fall) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// raster counters and scrolled read address
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d1 <= 1'b1;
			xcnt <= '0;
			ycnt <= '0;
			rd_addr <= '0;
		end else begin
			blank_d1 <= blank;
			xcnt <= blank ? coord_t'(0) : xcnt + 1'b1;
			if (vsync) begin
				ycnt <= '0;
			end else if (blank_rise) begin
				ycnt <= ycnt + 1'b1;
			end
			// column 799 maps to the newest write
			rd_addr <= wr_addr - buf_addr_t'(screen_width - 1) + buf_addr_t'(xcnt);
		end
	end

	// two stages to match rd_addr register plus memory read
	always_ff @(posedge clk) begin
		if (reset) begin
			view_x_d1 <= '0;
			view_y_d1 <= '0;
			view_x <= '0;
			view_y <= '0;
		end else begin
			view_x_d1 <= xcnt;
			view_y_d1 <= ycnt;
			view_x <= view_x_d1;
			view_y <= view_y_d1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/channel_minmax.sv
`default_nettype none

module channel_minmax (
	input  logic              clk,
	input  logic              reset,
	input  logic              sample_valid,
	input  scope_pkg::sample_t sample,
	input  logic              frame_start,
	output scope_pkg::sample_t frame_min,
	output scope_pkg::sample_t frame_max
);

	import scope_pkg::*;

	// empty pair, min above max so nothing draws
	localparam sample_t empty_min = '1;
	localparam sample_t empty_max = '0;

	sample_t run_min;
	sample_t run_max;

	always_ff @(posedge clk) begin
		if (reset) begin
			run_min <= empty_min;
			run_max <= empty_max;
			frame_min <= empty_min;
			frame_max <= empty_max;
		end else if (frame_start) begin
			frame_min <= run_min;
			frame_max <= run_max;
			// new frame starts from the coinciding sample if there is one
			if (sample_valid) begin
				run_min <= sample;
				run_max <= sample;
			end else begin
				run_min <= empty_min;
				run_max <= empty_max;
			end
		end else if (sample_valid) begin
			if (sample < run_min) begin
				run_min <= sample;
			end
			if (sample > run_max) begin
				run_max <= sample;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/trace_memory.sv
`default_nettype none

module trace_memory (
	input  logic                   clk,
	input  logic                   wr_en,
	input  scope_pkg::buf_addr_t   wr_addr,
	input  scope_pkg::trace_word_t wr_data,
	input  scope_pkg::buf_addr_t   rd_addr,
	output scope_pkg::trace_word_t rd_data
);

	import scope_pkg::*;

	localparam int depth = 1 << buf_addr_width;

	// one packed column word per frame
	trace_word_t mem [0:depth-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: hdl/trace_renderer.sv
`default_nettype none

module trace_renderer (
	input  logic                   clk,
	input  logic                   reset,
	input  scope_pkg::coord_t      view_x,
	input  scope_pkg::coord_t      view_y,
	input  scope_pkg::trace_word_t column,
	output scope_pkg::color_t      red,
	output scope_pkg::color_t      green,
	output scope_pkg::color_t      blue
);

	import scope_pkg::*;

	logic in_plot;
	logic grid_hit;
	logic [num_channels-1:0] band_hit;
	logic [23:0] pixel;

	assign in_plot = view_y >= coord_t'(plot_top);

	assign grid_hit = (&view_x[grid_x_bits-1:0]) || (view_y[grid_y_bits-1:0] == '0);

	//////////////////////////////////////////////////
	// band test per channel
	//////////////////////////////////////////////////

	for (genvar n = 0; n < num_channels; n++) begin : g_band
		// channel 0 sits in the top bytes of the column word
		localparam int slot = num_channels - 1 - n;

		trace_t lvl_max;
		trace_t lvl_min;
		coord_t rel_y;

		assign lvl_max = column[trace_width*(2*slot+1) +: trace_width];
		assign lvl_min = column[trace_width*(2*slot) +: trace_width];

		// rows above the band wrap to large values and miss
		assign rel_y = view_y - coord_t'(plot_top + n * channel_pitch);

		assign band_hit[n] = (coord_t'(lvl_min) <= rel_y) && (rel_y <= coord_t'(lvl_max));
	end

	//////////////////////////////////////////////////
	// color priority
	//////////////////////////////////////////////////

	always_comb begin
		if (!in_plot) begin
			pixel = color_black;
		end else if (band_hit[0]) begin
			pixel = color_a0;
		end else if (band_hit[1]) begin
			pixel = color_a1;
		end else if (band_hit[2]) begin
			pixel = color_b0;
		end else if (band_hit[3]) begin
			pixel = color_b1;
		end else if (grid_hit) begin
			pixel = color_grid;
		end else begin
			pixel = color_black;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			red <= pixel[23:16];
			green <= pixel[15:8];
			blue <= pixel[7:0];
		end
	end

endmodule

`default_nettype wire

// File: hdl/vga_scope.sv
`default_nettype none

module vga_scope (
	input  logic               clk,
	input  logic               reset,
	input  logic               blank,
	input  logic               vsync,
	input  logic               ad_strobe,
	input  scope_pkg::sample_t ad_a0,
	input  scope_pkg::sample_t ad_a1,
	input  scope_pkg::sample_t ad_b0,
	input  scope_pkg::sample_t ad_b1,
	output scope_pkg::color_t  red,
	output scope_pkg::color_t  green,
	output scope_pkg::color_t  blue
);

	import scope_pkg::*;

	logic frame_start;
	logic wr_en;
	buf_addr_t wr_addr;
	buf_addr_t rd_addr;
	coord_t view_x;
	coord_t view_y;
	sample_t a0_min, a0_max;
	sample_t a1_min, a1_max;
	sample_t b0_min, b0_max;
	sample_t b1_min, b1_max;
	trace_word_t wr_data;
	trace_word_t rd_data;

	scope_frame_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.blank       (blank),
		.vsync       (vsync),
		.frame_start (frame_start),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.rd_addr     (rd_addr),
		.view_x      (view_x),
		.view_y      (view_y)
	);

	//////////////////////////////////////////////////
	// per-channel min/max
	//////////////////////////////////////////////////

	channel_minmax u_minmax_a0 (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (ad_strobe),
		.sample       (ad_a0),
		.frame_start  (frame_start),
		.frame_min    (a0_min),
		.frame_max    (a0_max)
	);

	channel_minmax u_minmax_a1 (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (ad_strobe),
		.sample       (ad_a1),
		.frame_start  (frame_start),
		.frame_min    (a1_min),
		.frame_max    (a1_max)
	);

	channel_minmax u_minmax_b0 (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (ad_strobe),
		.sample       (ad_b0),
		.frame_start  (frame_start),
		.frame_min    (b0_min),
		.frame_max    (b0_max)
	);

	channel_minmax u_minmax_b1 (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (ad_strobe),
		.sample       (ad_b1),
		.frame_start  (frame_start),
		.frame_min    (b1_min),
		.frame_max    (b1_max)
	);

	// only the top bits are stored, max byte then min byte per channel
	assign wr_data = {
		a0_max[sample_width-1 -: trace_width], a0_min[sample_width-1 -: trace_width],
		a1_max[sample_width-1 -: trace_width], a1_min[sample_width-1 -: trace_width],
		b0_max[sample_width-1 -: trace_width], b0_min[sample_width-1 -: trace_width],
		b1_max[sample_width-1 -: trace_width], b1_min[sample_width-1 -: trace_width]
	};

	trace_memory u_memory (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	trace_renderer u_renderer (
		.clk    (clk),
		.reset  (reset),
		.view_x (view_x),
		.view_y (view_y),
		.column (rd_data),
		.red    (red),
		.green  (green),
		.blue   (blue)
	);

endmodule

`default_nettype wire

// File: bench/tb_vga_scope.sv
`default_nettype none

module tb_vga_scope;

	import scope_pkg::*;

	localparam int line_blank = 20;
	localparam int frame_lines = 360;
	localparam int vsync_lines = 4;
	// capture from 760 so the vertical grid line at 767 is included
	localparam int cap_first = 760;
	localparam int cap_size = (screen_width - cap_first) * frame_lines;
	localparam int max_lines = 64;

	logic clk;
	logic reset;
	logic blank;
	logic vsync;
	logic ad_strobe;
	sample_t ad_a0, ad_a1, ad_b0, ad_b1;
	color_t red, green, blue;

	// trace lines, each tagged with the count of F lines before it
	logic [4*sample_width-1:0] samp_val [0:max_lines-1];
	int samp_group [0:max_lines-1];
	logic [8*24-1:0] chk_name [0:max_lines-1];
	int chk_group [0:max_lines-1];
	int chk_x [0:max_lines-1];
	int chk_y [0:max_lines-1];
	logic [23:0] chk_rgb [0:max_lines-1];
	int num_samples;
	int num_checks;
	int num_frames;

	// pixels of the last displayed frame, column major
	logic [23:0] capture [0:cap_size-1];
	int captured;

	// last four driven cycles, index 3 is the one now on the RGB outputs
	// mode 1 expects black, mode 2 is captured
	int tag_x [0:3];
	int tag_y [0:3];
	int tag_mode [0:3];

	vga_scope u_vga_scope (
		.clk       (clk),
		.reset     (reset),
		.blank     (blank),
		.vsync     (vsync),
		.ad_strobe (ad_strobe),
		.ad_a0     (ad_a0),
		.ad_a1     (ad_a1),
		.ad_b0     (ad_b0),
		.ad_b1     (ad_b1),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic check_value(input logic [8*24-1:0] name, input logic [23:0] expected,
			input logic [23:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %0s expected %h actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// raster driver
	//////////////////////////////////////////////////

	// one clock, the pixel of the cycle three clocks back is read at the falling edge
	task automatic drive_cycle(input logic b, input logic v, input logic [4*sample_width-1:0] smp,
			input logic s, input int x, input int y, input int mode);
		int i;
		logic [23:0] rgb;
		@(posedge clk);
		blank <= b;
		vsync <= v;
		ad_strobe <= s;
		{ad_a0, ad_a1, ad_b0, ad_b1} <= smp;
		for (i = 3; i > 0; i--) begin
			tag_x[i] = tag_x[i-1];
			tag_y[i] = tag_y[i-1];
			tag_mode[i] = tag_mode[i-1];
		end
		tag_x[0] = x;
		tag_y[0] = y;
		tag_mode[0] = mode;
		@(negedge clk);
		rgb = {red, green, blue};
		if (tag_mode[3] == 1) begin
			check_value("reset_black", 24'h000000, rgb);
		end else if (tag_mode[3] == 2 && tag_x[3] >= cap_first) begin
			capture[(tag_x[3] - cap_first) * frame_lines + tag_y[3]] = rgb;
			captured++;
		end
	endtask

	// optional vsync lines, then 360 lines of 20 blank and 800 active cycles
	// the next sample of the group is strobed at x = 100 of a line
	task automatic run_frame(input int group, input logic with_vsync, input logic capture_on);
		int x;
		int y;
		int k;
		int mode;
		logic strobe_line;
		logic [4*sample_width-1:0] smp;
		k = 0;
		if (with_vsync) begin
			repeat (vsync_lines * (line_blank + screen_width)) begin
				drive_cycle(1'b1, 1'b1, '0, 1'b0, 0, 0, 0);
			end
		end
		for (y = 0; y < frame_lines; y++) begin
			while (k < num_samples && samp_group[k] < group) begin
				k++;
			end
			strobe_line = k < num_samples && samp_group[k] == group;
			smp = strobe_line ? samp_val[k] : '0;
			mode = capture_on ? 2 : (y < plot_top ? 1 : 0);
			repeat (line_blank) begin
				drive_cycle(1'b1, 1'b0, '0, 1'b0, 0, 0, 0);
			end
			for (x = 0; x < screen_width; x++) begin
				drive_cycle(1'b0, 1'b0, smp, strobe_line && x == 100, x, y, mode);
			end
			if (strobe_line) begin
				k++;
			end
		end
	endtask

	// S a0 a1 b0 b1, F, P name x y rgb, and # comment lines
	task automatic read_trace();
		int fd;
		logic ok;
		byte kind;
		sample_t v0, v1, v2, v3;
		logic [8*128-1:0] rest;
		fd = $fopen("bench/scope_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file bench/scope_trace.txt");
			$display("Test FAILED");
			$fatal(1, "no trace file");
		end
		num_samples = 0;
		num_checks = 0;
		num_frames = 0;
		while ($fscanf(fd, " %c", kind) == 1) begin
			ok = 1'b1;
			if (kind == "#") begin
				ok = $fgets(rest, fd) > 0;
			end else if (kind == "F") begin
				num_frames++;
			end else if (kind == "S" && num_samples < max_lines) begin
				ok = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3) == 4;
				samp_val[num_samples] = {v0, v1, v2, v3};
				samp_group[num_samples] = num_frames;
				num_samples++;
			end else if (kind == "P" && num_checks < max_lines) begin
				ok = $fscanf(fd, "%s %d %d %h", chk_name[num_checks], chk_x[num_checks],
					chk_y[num_checks], chk_rgb[num_checks]) == 4;
				chk_group[num_checks] = num_frames;
				num_checks++;
			end else begin
				ok = 1'b0;
			end
			if (!ok) begin
				$display("malformed or unexpected line in the trace file");
				$display("Test FAILED");
				$fatal(1, "bad trace file");
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int f;
		int c;
		int t;
		reset = 1'b1;
		blank = 1'b1;
		vsync = 1'b0;
		ad_strobe = 1'b0;
		{ad_a0, ad_a1, ad_b0, ad_b1} = '0;
		for (t = 0; t < 4; t++) begin
			tag_x[t] = 0;
			tag_y[t] = 0;
			tag_mode[t] = 0;
		end
		captured = 0;
		read_trace();
		repeat (8) begin
			@(posedge clk);
		end
		reset <= 1'b0;
		@(negedge clk);
		check_value("reset_rgb", 24'h000000, {red, green, blue});
		// frame 0 strobes the first group, nothing is written yet
		run_frame(0, 1'b0, 1'b0);
		// frame f shows group f-1 at column 799 and strobes group f
		for (f = 1; f <= num_frames; f++) begin
			captured = 0;
			run_frame(f, 1'b1, 1'b1);
			// the last pixels of the frame are still in the pipeline
			t = 0;
			while (captured < cap_size) begin
				if (t == 16) begin
					$display("capture of frame %0d did not complete", f);
					$display("Test FAILED");
					$fatal(1, "capture timeout");
				end
				drive_cycle(1'b1, 1'b0, '0, 1'b0, 0, 0, 0);
				t++;
			end
			for (c = 0; c < num_checks; c++) begin
				if (chk_group[c] == f) begin
					check_value(chk_name[c], chk_rgb[c],
						capture[(chk_x[c] - cap_first) * frame_lines + chk_y[c]]);
				end
			end
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/scope_trace.txt
# S a0 a1 b0 b1 : one strobed 12-bit sample per line, hex
# F : frame end | P name x y rgb : expected pixel, x and y decimal, rgb hex
S 100 005 000 04F
S 30F 20F 08A 0C3
S 200 100 040 080
F
P above_plot 799 223 000000
P grid_top 799 224 808080
P a0_edge_out 799 239 000000
P a0_first 799 240 FFFFFF
P a0_a1_overlap 799 260 FFFFFF
P a0_last 799 272 FFFFFF
P a1_only 799 273 FF0000
P a1_over_b0 799 288 FF0000
P b0_only 799 290 00FF00
P b0_edge_out 799 297 000000
P b1_first 799 324 0000FF
P b1_last 799 332 0000FF
P b1_edge_out 799 333 000000
P grid_col 767 300 808080
P grid_row 799 320 808080
S 500 F00 F00 F00
S 60C F10 F10 F10
F
P old_a0 798 250 FFFFFF
P old_b0 798 290 00FF00
P new_a0 799 304 FFFFFF
P new_edge_out 799 303 000000
P old_gone 799 250 000000
F
P empty_plot 799 310 000000
P empty_grid 799 256 808080
P scroll_b 798 310 FFFFFF
P scroll_a 797 290 00FF00

// File: filelist.f
common/scope_pkg.sv
hdl/scope_frame_ctrl.sv
hdl/channel_minmax.sv
hdl/trace_memory.sv
hdl/trace_renderer.sv
hdl/vga_scope.sv
bench/tb_vga_scope.sv
